//--- build.f
+incdir+src
src/conv_arith_pkg.sv
src/conv_frame_pkg.sv
src/line_window_gen.sv
src/row_mac_lane.sv
src/kernel_sum_stage.sv
src/conv3x3_top.sv
verif/conv3x3_assertions.sv
verif/conv3x3_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the conv3x3 testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module conv3x3_tb \
  -f build.f \
  -o conv3x3_sim

./obj_dir/conv3x3_sim 2>&1 | tee "$LOG"

if grep -qF '*** TEST PASSED ***' "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi

//--- verif/conv3x3_tb.sv
`timescale 1ns/1ps
`include "conv_params.svh"
`default_nettype none

module conv3x3_tb;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_STIM   = 10;
  localparam int NUM_TAPS   = `KERNEL * `KERNEL;
  localparam longint SCALE  = longint'(1) << `FRAC_BITS;
  localparam int PIX_MAX    = 32767;
  localparam int PIX_MIN    = -32768;

  // pixel patterns
  localparam int PAT_RAMP    = 0;
  localparam int PAT_RANDOM  = 1;
  localparam int PAT_EXTREME = 2;

  // weight sets
  localparam int W_IDENT = 0;
  localparam int W_SMALL = 1;
  localparam int W_FULL  = 2;
  localparam int W_MAX   = 3;
  localparam int W_MIN   = 4;

  typedef struct {
    int side;
    int frames;   // sent back to back with no idle cycles
    int wset;
    int bias;
    int pattern;
    int gap_pct;  // chance of an idle cycle before each pixel
  } stim_t;

  logic                   sys_clk;
  logic                   sys_rst_n;
  conv_frame_pkg::coord_t image_size;
  conv_arith_pkg::pixel_t pixel_in;
  logic                   pixel_valid;
  conv_arith_pkg::coefs_t weights [`KERNEL];
  conv_arith_pkg::coef_t  bias;
  conv_arith_pkg::pixel_t out_pixel;
  logic                   out_valid;

  stim_t stim_table [NUM_STIM];
  bit    table_ready = 1'b0;
  int    seed;
  int    cyc = 0;         // posedges seen so far
  int    out_count = 0;
  int    last_out = 0;    // value of the latest output pulse
  bit    have_out = 1'b0;
  int    w [NUM_TAPS];    // row-major kernel
  int    frame_mem [1024];
  int    exp_val_q [$];
  int    exp_time_q [$];

  conv3x3_top uut
  (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .image_size  (image_size),
    .pixel_in    (pixel_in),
    .pixel_valid (pixel_valid),
    .weights     (weights),
    .bias        (bias),
    .out_pixel   (out_pixel),
    .out_valid   (out_valid)
  );

  initial
  begin
    sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
  end

  always @(posedge sys_clk)
    cyc <= cyc + 1;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input longint got, input longint exp, input string what);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t ns: %s, got %0d, expected %0d",
                         $time, what, got, exp));
  endtask

  function automatic int rand_below(input int limit);
    int raw;
    raw = $random(seed);
    return int'((raw & 32'h7fff_ffff) % limit);
  endfunction

  task automatic load_table();
    stim_table[0] = '{2,  1, W_IDENT, 0,      PAT_RAMP,    0};   // prime rows only
    stim_table[1] = '{5,  1, W_IDENT, 0,      PAT_RAMP,    0};
    stim_table[2] = '{5,  1, W_IDENT, -100,   PAT_RAMP,    0};
    stim_table[3] = '{8,  1, W_SMALL, 37,     PAT_RANDOM,  0};
    stim_table[4] = '{16, 1, W_FULL,  -5,     PAT_RANDOM,  0};
    stim_table[5] = '{6,  1, W_MAX,   0,      PAT_EXTREME, 0};
    stim_table[6] = '{6,  1, W_MIN,   -32768, PAT_EXTREME, 0};
    stim_table[7] = '{16, 1, W_SMALL, -3,     PAT_RANDOM,  40};
    stim_table[8] = '{8,  2, W_SMALL, 12,     PAT_RANDOM,  25};
    stim_table[9] = '{7,  2, W_IDENT, 0,      PAT_RAMP,    0};   // new size after drain
  endtask

  task automatic load_weights(input int wset);
    for (int k = 0; k < NUM_TAPS; k++)
    begin
      case (wset)
        W_IDENT: w[k] = (k == NUM_TAPS / 2) ? int'(SCALE) : 0;
        W_SMALL: w[k] = rand_below(128) - 64;
        W_FULL:  w[k] = rand_below(65536) - 32768;
        W_MAX:   w[k] = PIX_MAX;
        default: w[k] = PIX_MIN;
      endcase
    end
  endtask

  function automatic int make_pixel(input int pattern, input int r, input int c, input int n);
    case (pattern)
      PAT_RAMP:    return (r * n + c) * 5 - 300;
      PAT_EXTREME: return (rand_below(2) == 1) ? PIX_MAX : PIX_MIN;
      default:     return rand_below(65536) - 32768;
    endcase
  endfunction

  // expected output for the window ending at row r and column c
  function automatic int golden_pixel(input int r, input int c, input int n, input int b);
    longint sum;
    longint q;
    sum = 0;
    for (int i = 0; i < `KERNEL; i++)
      for (int j = 0; j < `KERNEL; j++)
        sum += longint'(w[i * `KERNEL + j]) * longint'(frame_mem[(r - 2 + i) * n + c - 2 + j]);
    q = sum / SCALE;  // truncates toward zero
    if (sum < 0 && q * SCALE != sum)
      q = q - 1;
    q = q + b;
    if (q > PIX_MAX)
      q = PIX_MAX;
    else if (q < PIX_MIN)
      q = PIX_MIN;
    return int'(q);
  endfunction

  task automatic drive_pixel(input int value, input int gap_pct);
    @(negedge sys_clk);
    while (rand_below(100) < gap_pct)
    begin
      pixel_valid = 1'b0;
      pixel_in    = conv_arith_pkg::pixel_t'(rand_below(65536));  // noise while idle
      @(negedge sys_clk);
    end
    pixel_valid = 1'b1;
    pixel_in    = conv_arith_pkg::pixel_t'(value);
  endtask

  task automatic run_entry(input stim_t s);
    int first_count;
    int value;
    load_weights(s.wset);
    @(negedge sys_clk);
    image_size = conv_frame_pkg::coord_t'(s.side);
    bias       = conv_arith_pkg::coef_t'(s.bias);
    for (int i = 0; i < `KERNEL; i++)
      for (int j = 0; j < `KERNEL; j++)
        weights[i][j] = conv_arith_pkg::coef_t'(w[i * `KERNEL + j]);
    first_count = out_count;
    for (int f = 0; f < s.frames; f++)
      for (int r = 0; r < s.side; r++)
        for (int c = 0; c < s.side; c++)
        begin
          value = make_pixel(s.pattern, r, c, s.side);
          frame_mem[r * s.side + c] = value;
          drive_pixel(value, s.gap_pct);
          if (r >= 2 && c >= 2)
          begin
            exp_val_q.push_back(golden_pixel(r, c, s.side, s.bias));
            exp_time_q.push_back(cyc + `PIPE_LATENCY);  // accepting edge is cyc + 1
          end
        end
    @(negedge sys_clk);
    pixel_valid = 1'b0;
    while (exp_val_q.size() != 0)
      @(negedge sys_clk);
    repeat (3) @(negedge sys_clk);
    check_value(out_count - first_count, s.frames * (s.side - 2) * (s.side - 2),
                "output count of frame group");
  endtask

  // outputs are stable at the falling edge
  always @(negedge sys_clk)
  begin
    if (out_valid)
    begin
      if (exp_val_q.size() == 0)
        fail_run("Unexpected out_valid while no output was pending");
      else
      begin
        check_value(cyc, exp_time_q[0], "output edge");
        check_value(out_pixel, exp_val_q[0], "out_pixel");
        last_out = exp_val_q[0];
        have_out = 1'b1;
        void'(exp_val_q.pop_front());
        void'(exp_time_q.pop_front());
        out_count++;
      end
    end
    else if (exp_time_q.size() != 0 && exp_time_q[0] <= cyc)
      fail_run("An expected output did not appear on out_valid");
    else if (have_out)
      check_value(out_pixel, last_out, "out_pixel held between pulses");
  end

  initial
  begin : watchdog
    longint budget;
    int     max_gap;
    budget  = 0;
    max_gap = 0;
    wait (table_ready);
    for (int e = 0; e < NUM_STIM; e++)
    begin
      budget += stim_table[e].frames * stim_table[e].side * stim_table[e].side;
      if (stim_table[e].gap_pct > max_gap)
        max_gap = stim_table[e].gap_pct;
    end
    budget = budget * 100 / (100 - max_gap) * 2 + NUM_STIM * 50 + 200;
    #(budget * CLK_PERIOD);
    fail_run($sformatf("Timeout: the run did not finish within %0d cycles", budget));
  end

  initial
  begin
    seed        = 32'h17b30c4b;
    sys_rst_n   = 1'b0;
    pixel_valid = 1'b0;
    pixel_in    = '0;
    image_size  = '0;
    bias        = '0;
    for (int i = 0; i < `KERNEL; i++)
      for (int j = 0; j < `KERNEL; j++)
        weights[i][j] = '0;
    load_table();
    table_ready = 1'b1;
    repeat (4) @(posedge sys_clk);
    @(negedge sys_clk);
    sys_rst_n = 1'b1;
    for (int e = 0; e < NUM_STIM; e++)
      run_entry(stim_table[e]);
    $display("all %0d outputs matched", out_count);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/conv3x3_assertions.sv
`timescale 1ns/1ps
`include "conv_params.svh"
`default_nettype none

module conv3x3_assertions
(
  input logic                   sys_clk,
  input logic                   sys_rst_n,
  input logic                   pixel_valid,
  input logic                   out_valid,
  input conv_arith_pkg::pixel_t out_pixel
);

  // async reset holds the output strobe low
  reset_clears_valid: assert property (@(posedge sys_clk) !sys_rst_n |-> !out_valid)
    else $error("out_valid high while reset is asserted");

  // every output traces back to an accepted pixel
  latency_matches: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    out_valid |-> $past(pixel_valid, `PIPE_LATENCY))
    else $error("out_valid without an accepted pixel %0d cycles earlier", `PIPE_LATENCY);

  output_known: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    out_valid |-> !$isunknown(out_pixel))
    else $error("out_pixel has unknown bits while out_valid is high");

endmodule

bind conv3x3_top conv3x3_assertions u_assertions
(
  .sys_clk     (sys_clk),
  .sys_rst_n   (sys_rst_n),
  .pixel_valid (pixel_valid),
  .out_valid   (out_valid),
  .out_pixel   (out_pixel)
);

`default_nettype wire

//--- src/conv3x3_top.sv
`timescale 1ns/1ps
`include "conv_params.svh"
`default_nettype none

module conv3x3_top
(
  input  logic                   sys_clk,
  input  logic                   sys_rst_n,
  input  conv_frame_pkg::coord_t image_size,
  input  conv_arith_pkg::pixel_t pixel_in,
  input  logic                   pixel_valid,
  input  conv_arith_pkg::coefs_t weights [`KERNEL],  // row 0 pairs with the oldest line
  input  conv_arith_pkg::coef_t  bias,
  output conv_arith_pkg::pixel_t out_pixel,
  output logic                   out_valid
);

  logic                     win_valid;
  conv_arith_pkg::taps_t    win_rows  [`KERNEL];
  conv_arith_pkg::row_sum_t lane_sums [`KERNEL];
  logic [`KERNEL-1:0]       lane_valid;  // all lanes run in lockstep

  line_window_gen u_window
  (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .image_size  (image_size),
    .pixel_in    (pixel_in),
    .pixel_valid (pixel_valid),
    .win_valid   (win_valid),
    .win_row0    (win_rows[0]),
    .win_row1    (win_rows[1]),
    .win_row2    (win_rows[2])
  );

  // one multiply lane per kernel row
  for (genvar r = 0; r < `KERNEL; r++)
  begin : g_lane
    row_mac_lane u_lane
    (
      .sys_clk   (sys_clk),
      .sys_rst_n (sys_rst_n),
      .in_valid  (win_valid),
      .taps      (win_rows[r]),
      .coefs     (weights[r]),
      .sum_valid (lane_valid[r]),
      .row_sum   (lane_sums[r])
    );
  end

  kernel_sum_stage u_sum
  (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .in_valid  (lane_valid[0]),
    .row_sum0  (lane_sums[0]),
    .row_sum1  (lane_sums[1]),
    .row_sum2  (lane_sums[2]),
    .bias      (bias),
    .out_pixel (out_pixel),
    .out_valid (out_valid)
  );

endmodule

`default_nettype wire

//--- src/kernel_sum_stage.sv
`timescale 1ns/1ps
`include "conv_params.svh"
`default_nettype none

module kernel_sum_stage
(
  input  logic                     sys_clk,
  input  logic                     sys_rst_n,
  input  logic                     in_valid,
  input  conv_arith_pkg::row_sum_t row_sum0,
  input  conv_arith_pkg::row_sum_t row_sum1,
  input  conv_arith_pkg::row_sum_t row_sum2,
  input  conv_arith_pkg::coef_t    bias,
  output conv_arith_pkg::pixel_t   out_pixel,
  output logic                     out_valid
);

  // pixel range expressed in accumulator width
  localparam conv_arith_pkg::acc_t SAT_MAX = conv_arith_pkg::acc_t'(2 ** (`PIX_W - 1) - 1);
  localparam conv_arith_pkg::acc_t SAT_MIN = -SAT_MAX - 1;

  conv_arith_pkg::acc_t   scaled_bias;
  conv_arith_pkg::acc_t   acc;
  conv_arith_pkg::acc_t   acc_shifted;
  conv_arith_pkg::pixel_t sat_pixel;
  logic                   acc_valid;

  // bias moved onto the product scale so one shift covers both
  assign scaled_bias = conv_arith_pkg::acc_t'(bias) <<< `FRAC_BITS;

  always_ff @(posedge sys_clk)
  begin
    if (in_valid)
      acc <= conv_arith_pkg::acc_t'(row_sum0) + conv_arith_pkg::acc_t'(row_sum1)
           + conv_arith_pkg::acc_t'(row_sum2) + scaled_bias;
  end

  assign acc_shifted = acc >>> `FRAC_BITS;  // floor toward minus infinity

  always_comb
  begin
    if (acc_shifted > SAT_MAX)
      sat_pixel = conv_arith_pkg::pixel_t'(SAT_MAX);
    else if (acc_shifted < SAT_MIN)
      sat_pixel = conv_arith_pkg::pixel_t'(SAT_MIN);
    else
      sat_pixel = conv_arith_pkg::pixel_t'(acc_shifted);
  end

  // held between output pulses
  always_ff @(posedge sys_clk)
  begin
    if (acc_valid)
      out_pixel <= sat_pixel;
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      acc_valid <= 1'b0;
      out_valid <= 1'b0;
    end
    else
    begin
      acc_valid <= in_valid;
      out_valid <= acc_valid;
    end
  end

endmodule

`default_nettype wire

//--- src/row_mac_lane.sv
`timescale 1ns/1ps
`include "conv_params.svh"
`default_nettype none

module row_mac_lane
(
  input  logic                     sys_clk,
  input  logic                     sys_rst_n,
  input  logic                     in_valid,
  input  conv_arith_pkg::taps_t    taps,
  input  conv_arith_pkg::coefs_t   coefs,
  output logic                     sum_valid,
  output conv_arith_pkg::row_sum_t row_sum
);

  conv_arith_pkg::product_t prod [`KERNEL];
  conv_arith_pkg::row_sum_t prod_total;
  logic                     prod_valid;

  // stage 1, one signed multiply per tap
  always_ff @(posedge sys_clk)
  begin
    if (in_valid)
      for (int i = 0; i < `KERNEL; i++)
        prod[i] <= taps[i] * coefs[i];
  end

  // sign extended sum, guard bits absorb the carries
  always_comb
  begin
    prod_total = '0;
    for (int i = 0; i < `KERNEL; i++)
      prod_total = prod_total + conv_arith_pkg::row_sum_t'(prod[i]);
  end

  // stage 2
  always_ff @(posedge sys_clk)
  begin
    if (prod_valid)
      row_sum <= prod_total;
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      prod_valid <= 1'b0;
      sum_valid  <= 1'b0;
    end
    else
    begin
      prod_valid <= in_valid;
      sum_valid  <= prod_valid;
    end
  end

endmodule

`default_nettype wire

//--- src/line_window_gen.sv
`timescale 1ns/1ps
`include "conv_params.svh"
`default_nettype none

module line_window_gen
(
  input  logic                   sys_clk,
  input  logic                   sys_rst_n,
  input  conv_frame_pkg::coord_t image_size,
  input  conv_arith_pkg::pixel_t pixel_in,
  input  logic                   pixel_valid,
  output logic                   win_valid,
  output conv_arith_pkg::taps_t  win_row0,
  output conv_arith_pkg::taps_t  win_row1,
  output conv_arith_pkg::taps_t  win_row2
);

  conv_frame_pkg::coord_t       col_cnt;
  conv_frame_pkg::coord_t       row_cnt;
  conv_frame_pkg::coord_t       last_idx;
  conv_frame_pkg::frame_phase_e phase;
  logic                         col_wrap;
  logic                         row_wrap;

  // previous two lines, indexed by column
  conv_arith_pkg::pixel_t       line_two_back [`LINE_MAX];
  conv_arith_pkg::pixel_t       line_one_back [`LINE_MAX];
  conv_arith_pkg::pixel_t       rd_two_back;
  conv_arith_pkg::pixel_t       rd_one_back;

  assign last_idx = image_size - 1'b1;
  assign col_wrap = (col_cnt == last_idx);
  assign row_wrap = (row_cnt == last_idx);

  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      col_cnt <= '0;
      row_cnt <= '0;
    end
    else if (pixel_valid)
    begin
      if (col_wrap)
      begin
        col_cnt <= '0;
        row_cnt <= row_wrap ? '0 : row_cnt + 1'b1;  // next frame starts at once
      end
      else
        col_cnt <= col_cnt + 1'b1;
    end
  end

  always_comb
  begin
    if (row_cnt < 2)
      phase = conv_frame_pkg::PHASE_PRIME;
    else if (col_cnt < 2)
      phase = conv_frame_pkg::PHASE_EDGE;  // window would wrap to the previous row
    else
      phase = conv_frame_pkg::PHASE_SLIDE;
  end

  // read before write at the same column
  assign rd_two_back = line_two_back[col_cnt];
  assign rd_one_back = line_one_back[col_cnt];

  always_ff @(posedge sys_clk)
  begin
    if (pixel_valid)
    begin
      line_two_back[col_cnt] <= rd_one_back;  // age one line
      line_one_back[col_cnt] <= pixel_in;
    end
  end

  // window columns shift left, newest column enters at the top index
  always_ff @(posedge sys_clk)
  begin
    if (pixel_valid)
    begin
      for (int i = 0; i < `KERNEL - 1; i++)
      begin
        win_row0[i] <= win_row0[i+1];
        win_row1[i] <= win_row1[i+1];
        win_row2[i] <= win_row2[i+1];
      end
      win_row0[`KERNEL-1] <= rd_two_back;
      win_row1[`KERNEL-1] <= rd_one_back;
      win_row2[`KERNEL-1] <= pixel_in;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
      win_valid <= 1'b0;
    else
      win_valid <= pixel_valid && (phase == conv_frame_pkg::PHASE_SLIDE);
  end

endmodule

`default_nettype wire

//--- src/conv_frame_pkg.sv
`include "conv_params.svh"
`default_nettype none

package conv_frame_pkg;

  // row or column index, also carries the frame side
  typedef logic [`COORD_W-1:0] coord_t;

  // where the current pixel sits in the frame
  typedef enum logic [1:0]
  {
    PHASE_PRIME = 2'd0,  // first two rows, lines still filling
    PHASE_EDGE  = 2'd1,  // left two columns of a later row
    PHASE_SLIDE = 2'd2   // full 3x3 window available
  } frame_phase_e;

endpackage

`default_nettype wire

//--- src/conv_arith_pkg.sv
`include "conv_params.svh"
`default_nettype none

package conv_arith_pkg;

  // one image sample and one kernel coefficient
  typedef logic signed [`PIX_W-1:0]  pixel_t;
  typedef logic signed [`COEF_W-1:0] coef_t;

  // one row of the sliding window, index 0 is the oldest column
  typedef pixel_t taps_t [`KERNEL];

  // one row of the kernel, same column order as taps_t
  typedef coef_t coefs_t [`KERNEL];

  // full precision product
  typedef logic signed [`PIX_W+`COEF_W-1:0] product_t;

  // three products plus two guard bits
  typedef logic signed [`PIX_W+`COEF_W+1:0] row_sum_t;

  // three row sums and the scaled bias, four guard bits
  typedef logic signed [`PIX_W+`COEF_W+3:0] acc_t;

endpackage

`default_nettype wire

//--- src/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// data path widths
`define PIX_W        16
`define COEF_W       16
`define FRAC_BITS    8     // weights are Q7.8

// window and frame geometry
`define KERNEL       3
`define LINE_MAX     512   // must equal 2**COORD_W
`define COORD_W      9

// accepting edge to out_valid, in cycles
// window 1, row lanes 2, kernel sum 2
`define PIPE_LATENCY 5

`endif
